// ==== rtl/dac_pkg.sv ====
package dac_pkg;

    // ----------------------------------------
    // host register map
    // ----------------------------------------

    localparam logic [3:0] addr_main    = 4'h0;  // space nibble, reg_waddr[15:12]
    localparam logic [3:0] off_dac_ctrl = 4'h0;  // offset within a channel, reg_waddr[3:0]

    // channel nibble reg_waddr[7:4] runs 1 .. num_channels
    localparam int num_channels = 4;             // dacs on the daisy chain

    // ----------------------------------------
    // ltc2601 command set
    // ----------------------------------------

    localparam logic [3:0]  dac_cmd_wru  = 4'h3;     // write input reg and update output
    localparam logic [3:0]  dac_cmd_nop  = 4'hf;     // no operation
    localparam logic [15:0] dac_val_init = 16'h8000; // mid-scale, zero motor current

    // ----------------------------------------
    // frame and serial timing
    // ----------------------------------------

    localparam int word_bits  = 32;   // one command word per dac
    localparam int frame_bits = 128;  // num_channels * word_bits
    localparam int bit_cycles = 4;    // sysclk cycles per sclk period, even, at least 4

    // a command word, built field by field in the register block
    // and shifted out as a flat vector by the serializer
    typedef union packed {
        struct packed {
            logic [7:0]  pad;    // don't care bits for the 24-bit ltc2601 frame
            logic [3:0]  cmd;    // command code
            logic [3:0]  addr;   // address nibble, unused by ltc2601
            logic [15:0] value;  // dac code
        } fields;
        logic [word_bits-1:0] raw;
    } dac_word_u;

    // idle word, 00f08000
    // the send set returns to this once a word is on the wire
    localparam dac_word_u nop_word = dac_word_u'({8'h00, dac_cmd_nop, 4'h0, dac_val_init});

endpackage

// ==== rtl/dac_cmd_regs.sv ====
`timescale 1ns/1ps

module dac_cmd_regs (
    // clock and reset
    input  logic               sysclk,     // system clock
    input  logic               rst_n,      // async reset, active low
    // host write side
    input  logic               reg_wen,    // single cycle write strobe
    input  logic               blk_wen,    // end of block strobe
    input  logic [15:0]        reg_waddr,  // write address
    input  logic [15:0]        reg_wdata,  // current set-point
    // host read side
    input  logic [3:0]         reg_rchan,  // read channel, 1 .. 4
    output dac_pkg::dac_word_u reg_rdata,  // last word written to that channel
    // readback values
    output logic [15:0]        dac1,
    output logic [15:0]        dac2,
    output logic [15:0]        dac3,
    output logic [15:0]        dac4,
    // serializer side
    output logic               trig,       // starts one spi frame
    output dac_pkg::dac_word_u word,       // send entry at addr
    input  logic               busy,       // frame in flight
    input  logic               flush,      // word at addr is out, clear it
    input  logic [1:0]         addr        // channel index the serializer is on
);

    // ----------------------------------------
    // host address decode
    // ----------------------------------------

    logic       space_ok;   // main register space
    logic       chan_ok;    // channel 1 .. 4
    logic       off_ok;     // dac control offset
    logic       waddr_dac;  // address hits a dac control register
    logic       wr_ok;      // write accepted this cycle
    logic [1:0] wr_idx;     // channel minus one

    assign space_ok  = (reg_waddr[15:12] == dac_pkg::addr_main);
    assign chan_ok   = (reg_waddr[7:4] != 4'd0) && (reg_waddr[7:4] <= dac_pkg::num_channels);
    assign off_ok    = (reg_waddr[3:0] == dac_pkg::off_dac_ctrl);
    assign waddr_dac = space_ok && chan_ok && off_ok;

    assign wr_ok  = reg_wen && waddr_dac && !busy;  // dropped while a frame is out
    assign wr_idx = reg_waddr[5:4] - 2'd1;          // 1..4 -> 0..3, channel 4 wraps to 3

    // write-and-update word carrying the new set-point
    dac_pkg::dac_word_u wru_word;

    always_comb begin
        wru_word.fields.pad   = 8'h00;
        wru_word.fields.cmd   = dac_pkg::dac_cmd_wru;
        wru_word.fields.addr  = 4'h0;
        wru_word.fields.value = reg_wdata;
    end

    // ----------------------------------------
    // send set and readback copy
    // ----------------------------------------

    dac_pkg::dac_word_u send_mem [dac_pkg::num_channels];  // cleared to nop after shifting
    dac_pkg::dac_word_u copy_mem [dac_pkg::num_channels];  // keeps last write per channel

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dac_pkg::num_channels; i++) begin
                send_mem[i] <= dac_pkg::nop_word;
                copy_mem[i] <= dac_pkg::nop_word;
            end
        end else if (flush) begin
            // only comes while busy, so no host write can be lost here
            send_mem[addr] <= dac_pkg::nop_word;
        end else if (wr_ok) begin
            send_mem[wr_idx] <= wru_word;
            copy_mem[wr_idx] <= wru_word;
        end
    end

    assign word = send_mem[addr];  // serializer fetch port

    // ----------------------------------------
    // trigger
    // ----------------------------------------

    // one cycle late, so a write that shares the cycle
    // with blk_wen is in send_mem before the frame loads
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            trig <= 1'b0;
        end else begin
            trig <= blk_wen && waddr_dac && !busy;
        end
    end

    // ----------------------------------------
    // readback
    // ----------------------------------------

    logic       rd_ok;
    logic [1:0] rd_idx;

    assign rd_ok  = (reg_rchan != 4'd0) && (reg_rchan <= dac_pkg::num_channels);
    assign rd_idx = reg_rchan[1:0] - 2'd1;

    assign reg_rdata = rd_ok ? copy_mem[rd_idx] : '0;  // out of range reads zero

    // commanded currents
    assign dac1 = copy_mem[0].fields.value;
    assign dac2 = copy_mem[1].fields.value;
    assign dac3 = copy_mem[2].fields.value;
    assign dac4 = copy_mem[3].fields.value;

endmodule

// ==== rtl/dac_spi_chain.sv ====
`timescale 1ns/1ps

module dac_spi_chain (
    input  logic               sysclk,  // system clock
    input  logic               rst_n,   // async reset, active low
    input  logic               trig,    // start a frame, ignored while busy
    input  dac_pkg::dac_word_u word,    // send entry at addr
    output logic [1:0]         addr,    // channel being fetched or flushed
    output logic               sclk,    // serial clock, idles low
    output logic               csel,    // chip select, active low
    output logic               mosi,    // serial data, msb first
    output logic               busy,    // frame in flight
    output logic               flush    // word at addr has been sampled
);

    // ----------------------------------------
    // frame sequencing state
    // ----------------------------------------

    logic [$clog2(dac_pkg::bit_cycles)-1:0] phase;    // sysclk count within one bit
    logic [$clog2(dac_pkg::frame_bits)-1:0] bit_cnt;  // bit position in frame
    logic [dac_pkg::word_bits-1:0]          sreg;     // shift register, msb on the wire
    logic                                   tail;     // csel back up, busy drops next

    logic phase_end;       // last sysclk of the current bit
    logic phase_mid;       // sclk rises on the next edge
    logic last_bit;        // bit 31 of a word
    logic last_frame_bit;  // bit 31 of the channel 1 word

    assign phase_end = (int'(phase) == dac_pkg::bit_cycles - 1);
    assign phase_mid = (int'(phase) == dac_pkg::bit_cycles / 2 - 1);

    // low bits of bit_cnt give the bit index within the word
    assign last_bit       = (int'(bit_cnt[$clog2(dac_pkg::word_bits)-1:0])
                            == dac_pkg::word_bits - 1);
    assign last_frame_bit = (int'(bit_cnt) == dac_pkg::frame_bits - 1);

    assign mosi = sreg[dac_pkg::word_bits-1];  // sreg only moves while sclk is low

    // ----------------------------------------
    // serializer
    // ----------------------------------------

    // per bit: sclk low for the first half, high for the second
    // flush sits in the first high cycle of a word's last bit,
    // addr steps on the same edge it drops so the next word
    // is ready one cycle before it loads
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            addr    <= 2'(dac_pkg::num_channels - 1);
            sclk    <= 1'b0;
            csel    <= 1'b1;
            busy    <= 1'b0;
            flush   <= 1'b0;
            tail    <= 1'b0;
            phase   <= '0;
            bit_cnt <= '0;
            sreg    <= '0;
        end else begin
            flush <= 1'b0;  // one cycle pulse
            if (!busy) begin
                if (trig) begin
                    // addr idles on channel 4, its word goes first
                    busy    <= 1'b1;
                    csel    <= 1'b0;
                    phase   <= '0;
                    bit_cnt <= '0;
                    sreg    <= word.raw;
                end
            end else if (tail) begin
                busy <= 1'b0;
                tail <= 1'b0;
                addr <= 2'(dac_pkg::num_channels - 1);  // ready for next frame
            end else begin
                if (flush && !last_frame_bit) begin
                    addr <= addr - 2'd1;  // prefetch next channel
                end
                if (phase_end) begin
                    phase   <= '0;
                    sclk    <= 1'b0;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (last_frame_bit) begin
                        // all four words out
                        sreg <= '0;
                        csel <= 1'b1;
                        tail <= 1'b1;
                    end else if (last_bit) begin
                        sreg <= word.raw;  // word boundary
                    end else begin
                        sreg <= {sreg[dac_pkg::word_bits-2:0], 1'b0};
                    end
                end else begin
                    phase <= phase + 1'b1;
                    if (phase_mid) begin
                        sclk  <= 1'b1;      // dacs sample here
                        flush <= last_bit;  // whole word now on the wire
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/dac_ctrl_top.sv ====
`timescale 1ns/1ps

module dac_ctrl_top (
    input  logic               sysclk,     // system clock
    input  logic               rst_n,      // async reset, active low
    // host register bus
    input  logic               reg_wen,    // write strobe
    input  logic               blk_wen,    // end of block
    input  logic [15:0]        reg_waddr,
    input  logic [15:0]        reg_wdata,  // current set-point
    input  logic [3:0]         reg_rchan,  // readback channel
    output dac_pkg::dac_word_u reg_rdata,
    // spi to the dac chain
    output logic               sclk,
    output logic               mosi,
    output logic               csel,
    // commanded currents
    output logic [15:0]        dac1,
    output logic [15:0]        dac2,
    output logic [15:0]        dac3,
    output logic [15:0]        dac4
);

    // ----------------------------------------
    // register block to serializer
    // ----------------------------------------

    logic               trig;   // frame start
    logic               busy;   // frame in flight
    logic               flush;  // clear send entry at addr
    logic [1:0]         addr;   // serializer channel index
    dac_pkg::dac_word_u word;   // send entry at addr

    dac_cmd_regs u_regs (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_rchan (reg_rchan),
        .reg_rdata (reg_rdata),
        .dac1      (dac1),
        .dac2      (dac2),
        .dac3      (dac3),
        .dac4      (dac4),
        .trig      (trig),
        .word      (word),
        .busy      (busy),
        .flush     (flush),
        .addr      (addr)
    );

    dac_spi_chain u_spi (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .trig   (trig),
        .word   (word),
        .addr   (addr),
        .sclk   (sclk),
        .csel   (csel),
        .mosi   (mosi),
        .busy   (busy),
        .flush  (flush)
    );

endmodule

// ==== verification/dac_ctrl_assert.sv ====
`timescale 1ns/1ps

module dac_spi_chain_assert (
    input logic sysclk,
    input logic rst_n,
    input logic sclk,
    input logic csel,
    input logic mosi,
    input logic busy,
    input logic flush
);

    // ----------------------------------------
    // spi protocol
    // ----------------------------------------

    // no clock edges reach the dacs while deselected
    a_sclk_idle: assert property (@(posedge sysclk) disable iff (!rst_n)
        csel |-> !sclk)
        else $error("sclk high while csel is high");

    a_flush_busy: assert property (@(posedge sysclk) disable iff (!rst_n)
        flush |-> busy)
        else $error("flush pulse outside a frame");

    // data held across the whole high half of sclk
    a_mosi_stable: assert property (@(posedge sysclk) disable iff (!rst_n)
        sclk |-> $stable(mosi))
        else $error("mosi changed while sclk was high");

endmodule

bind dac_spi_chain dac_spi_chain_assert u_spi_assert (
    .sysclk (sysclk),
    .rst_n  (rst_n),
    .sclk   (sclk),
    .csel   (csel),
    .mosi   (mosi),
    .busy   (busy),
    .flush  (flush)
);

// ==== verification/tb_dac_ctrl.sv ====
`timescale 1ns/1ps

module tb_dac_ctrl;

    localparam int num_tests   = 6;
    localparam int max_frames  = 56;   // upper bound on frames over all tests
    localparam int frame_limit = 600;  // cycles allowed for one 514 cycle frame

    // ----------------------------------------
    // dut ports
    // ----------------------------------------

    logic               sysclk;
    logic               rst_n;
    logic               reg_wen;
    logic               blk_wen;
    logic [15:0]        reg_waddr;
    logic [15:0]        reg_wdata;
    logic [3:0]         reg_rchan;
    dac_pkg::dac_word_u reg_rdata;
    logic               sclk;
    logic               mosi;
    logic               csel;
    logic [15:0]        dac1;
    logic [15:0]        dac2;
    logic [15:0]        dac3;
    logic [15:0]        dac4;

    dac_ctrl_top i_dut (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_rchan (reg_rchan),
        .reg_rdata (reg_rdata),
        .sclk      (sclk),
        .mosi      (mosi),
        .csel      (csel),
        .dac1      (dac1),
        .dac2      (dac2),
        .dac3      (dac3),
        .dac4      (dac4)
    );

    // model of the two word sets
    logic         send_pend [4];  // channel written since the last frame
    logic [15:0]  send_val  [4];
    logic         rb_set    [4];  // channel ever written
    logic [15:0]  rb_val    [4];  // readback values that are never cleared
    logic         in_flight;      // model says a frame is out
    logic [127:0] exp_q [$];      // expected frames with the oldest first

    int    frames_accepted = 0;
    int    frames_checked  = 0;
    int    err_count       = 0;
    int    test_errs       = 0;
    int    test_num        = 0;
    int    tests_clean     = 0;
    int    check_count     = 0;
    string test_name;

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;  // 100 MHz
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic dac_pkg::dac_word_u build_word(input logic [3:0] cmd,
                                                      input logic [15:0] value);
        dac_pkg::dac_word_u w;
        w.fields.pad   = 8'h00;
        w.fields.cmd   = cmd;
        w.fields.addr  = 4'h0;
        w.fields.value = value;
        return w;
    endfunction

    // dac control register of channel 1 .. 4 in the main space at offset 0
    function automatic logic hits_dac(input logic [15:0] a);
        return (a[15:12] == 4'h0) && (a[7:4] >= 4'd1) && (a[7:4] <= 4'd4) && (a[3:0] == 4'h0);
    endfunction

    // channel 4 word sits on top as it leaves first
    function automatic logic [127:0] ref_frame();
        logic [127:0]       frame;
        dac_pkg::dac_word_u w;
        for (int ch = 0; ch < 4; ch++) begin
            if (send_pend[ch])
                w = build_word(dac_pkg::dac_cmd_wru, send_val[ch]);
            else
                w = build_word(dac_pkg::dac_cmd_nop, dac_pkg::dac_val_init);
            frame[ch*32 +: 32] = w.raw;
        end
        return frame;
    endfunction

    function automatic dac_pkg::dac_word_u rb_word(input int idx);
        if (rb_set[idx])
            return build_word(dac_pkg::dac_cmd_wru, rb_val[idx]);
        return build_word(dac_pkg::dac_cmd_nop, dac_pkg::dac_val_init);
    endfunction

    // mostly legal with now and then a bad space or offset
    function automatic logic [15:0] rand_addr();
        logic [3:0] space;
        logic [3:0] off;
        space = ($urandom_range(0, 7) == 0) ? 4'($urandom_range(1, 15)) : 4'h0;
        off   = ($urandom_range(0, 7) == 0) ? 4'($urandom_range(1, 15)) : 4'h0;
        return {space, 4'($urandom), 4'($urandom_range(0, 5)), off};
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic check_word(input string what, input dac_pkg::dac_word_u got,
                              input dac_pkg::dac_word_u exp);
        check_count++;
        if (got !== exp) begin
            $display("error at %0t: %s is %08h, expected %08h", $time, what, got.raw, exp.raw);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("error at %0t: %s is %04h, expected %04h", $time, what, got, exp);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            err_count++;
            test_errs++;
        end
    endtask

    // ----------------------------------------
    // frame capture and compare
    // ----------------------------------------

    logic [127:0] shift_frame;
    logic [127:0] cap_frame;
    int           bits_seen = 0;
    event         frame_done;

    always @(posedge sclk or posedge csel) begin
        if (csel) begin
            if (bits_seen != 0) begin  // end of a frame and not the reset edge
                if (bits_seen != dac_pkg::frame_bits) begin
                    $display("error at %0t: frame ended after %0d bits", $time, bits_seen);
                    err_count++;
                    test_errs++;
                end
                cap_frame = shift_frame;
                bits_seen = 0;
                -> frame_done;
            end
        end else begin
            shift_frame = {shift_frame[126:0], mosi};  // msb first
            bits_seen++;
        end
    end

    always begin : compare_frames
        logic [127:0]       exp_frame;
        dac_pkg::dac_word_u got_w;
        dac_pkg::dac_word_u exp_w;
        @(frame_done);
        if (exp_q.size() == 0) begin
            $display("test %0d: a frame went out with no accepted trigger", test_num);
            err_count++;
            test_errs++;
        end else begin
            exp_frame = exp_q.pop_front();
            for (int ch = 3; ch >= 0; ch--) begin
                got_w.raw = cap_frame[ch*32 +: 32];
                exp_w.raw = exp_frame[ch*32 +: 32];
                check_word($sformatf("frame %0d channel %0d", frames_checked + 1, ch + 1),
                           got_w, exp_w);
            end
        end
        frames_checked++;
    end

    // ----------------------------------------
    // host bus tasks
    // ----------------------------------------

    task automatic host_write(input logic [15:0] a, input logic [15:0] data);
        @(negedge sysclk);
        reg_waddr = a;
        reg_wdata = data;
        reg_wen   = 1'b1;
        if (hits_dac(a) && !in_flight) begin  // dropped while a frame is out
            send_pend[a[5:4] - 2'd1] = 1'b1;
            send_val[a[5:4] - 2'd1]  = data;
            rb_set[a[5:4] - 2'd1]    = 1'b1;
            rb_val[a[5:4] - 2'd1]    = data;
        end
        @(negedge sysclk);
        reg_wen = 1'b0;
    endtask

    task automatic host_trigger(input logic [15:0] a);
        @(negedge sysclk);
        reg_waddr = a;
        blk_wen   = 1'b1;
        if (hits_dac(a) && !in_flight) begin
            exp_q.push_back(ref_frame());
            for (int ch = 0; ch < 4; ch++)
                send_pend[ch] = 1'b0;  // flushed as the words go out
            in_flight = 1'b1;
            frames_accepted++;
        end
        @(negedge sysclk);
        blk_wen = 1'b0;
    endtask

    task automatic read_chan(input logic [3:0] ch, output dac_pkg::dac_word_u data);
        @(negedge sysclk);
        reg_rchan = ch;
        @(posedge sysclk);
        data = reg_rdata;
    endtask

    task automatic check_readback();
        dac_pkg::dac_word_u got;
        for (int ch = 1; ch <= 4; ch++) begin
            read_chan(4'(ch), got);
            check_word($sformatf("readback channel %0d", ch), got, rb_word(ch - 1));
        end
        check_value("dac1", dac1, rb_val[0]);
        check_value("dac2", dac2, rb_val[1]);
        check_value("dac3", dac3, rb_val[2]);
        check_value("dac4", dac4, rb_val[3]);
    endtask

    task automatic wait_csel_low();
        int n;
        n = 0;
        while (csel && n < 20) begin
            @(negedge sysclk);
            n++;
        end
        if (csel) begin
            $display("test %0d: chip select never went low after the trigger", test_num);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic wait_frame();
        int n;
        n = 0;
        while (frames_checked < frames_accepted && n < frame_limit) begin
            @(negedge sysclk);
            n++;
        end
        if (frames_checked < frames_accepted) begin
            $display("test %0d: no complete frame within %0d cycles of the trigger",
                     test_num, frame_limit);
            err_count++;
            test_errs++;
        end
        repeat (2) @(negedge sysclk);  // busy drops one cycle after csel
        in_flight = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0)
            tests_clean++;
        $display("test %0d %s: %0d mismatches", test_num, test_name, test_errs);
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    initial begin : stimulus
        dac_pkg::dac_word_u got;
        int                 nwr;
        logic [15:0]        a;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'ha7548d60));
        rst_n     = 1'b0;
        reg_wen   = 1'b0;
        blk_wen   = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_rchan = '0;
        in_flight = 1'b0;
        for (int ch = 0; ch < 4; ch++) begin
            send_pend[ch] = 1'b0;
            send_val[ch]  = '0;
            rb_set[ch]    = 1'b0;
            rb_val[ch]    = dac_pkg::dac_val_init;  // mid-scale after reset
        end
        repeat (16) @(negedge sysclk);
        rst_n = 1'b1;
        repeat (2) @(negedge sysclk);

        start_test("reset state");
        check_bit("csel", csel, 1'b1);
        check_bit("sclk", sclk, 1'b0);
        check_readback();
        read_chan(4'd0, got);
        check_word("readback channel 0", got, '0);
        read_chan(4'd5, got);
        check_word("readback channel 5", got, '0);
        end_test();

        start_test("write channels 1 and 3");
        host_write(16'h0010, 16'h1234);
        host_write(16'h0030, 16'hbeef);
        host_trigger(16'h0010);
        wait_frame();
        check_readback();
        end_test();

        start_test("second frame after flush");
        host_trigger(16'h0040);
        wait_frame();  // nops only
        check_readback();
        end_test();

        start_test("writes during a frame");
        host_write(16'h0020, 16'h4321);
        host_trigger(16'h0020);
        wait_csel_low();
        repeat (40) @(negedge sysclk);
        host_write(16'h0040, 16'h7777);  // dropped while busy
        host_write(16'h0020, 16'h0001);
        host_trigger(16'h0030);          // no queueing
        wait_frame();
        check_readback();
        host_trigger(16'h0010);
        wait_frame();
        end_test();

        start_test("bad addresses");
        host_write(16'h1010, 16'h1111);  // wrong space
        host_write(16'h0000, 16'h2222);  // channel 0
        host_write(16'h0050, 16'h3333);  // channel 5
        host_write(16'h00f0, 16'h4444);
        host_write(16'h0012, 16'h5555);  // wrong offset
        host_trigger(16'h0060);
        host_trigger(16'h2010);
        host_trigger(16'h0011);
        repeat (30) @(negedge sysclk);
        check_bit("csel after rejected block end", csel, 1'b1);
        host_trigger(16'h0040);
        wait_frame();
        check_readback();
        end_test();

        start_test("random rounds");
        for (int r = 0; r < 50; r++) begin
            nwr = $urandom_range(0, 4);
            repeat (nwr) host_write(rand_addr(), 16'($urandom));
            if ($urandom_range(0, 7) == 0)
                a = rand_addr();
            else
                a = {4'h0, 4'($urandom), 4'($urandom_range(1, 4)), 4'h0};
            host_trigger(a);
            if (in_flight)
                wait_frame();
            check_readback();
        end
        end_test();

        $display("summary: %0d tests, %0d clean, %0d checks, %0d errors",
                 test_num, tests_clean, check_count, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // hard stop if a frame or a wait hangs
    initial begin : watchdog
        repeat (num_tests * max_frames * frame_limit) @(posedge sysclk);
        $display("timeout: the run did not finish within %0d clock cycles",
                 num_tests * max_frames * frame_limit);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/dac_pkg.sv
rtl/dac_cmd_regs.sv
rtl/dac_spi_chain.sv
rtl/dac_ctrl_top.sv
verification/dac_ctrl_assert.sv
verification/tb_dac_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DAC controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module tb_dac_ctrl \
    -o sim_dac_ctrl

./obj_dir/sim_dac_ctrl | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation PASS"
    exit 0
else
    echo "simulation FAIL, see sim.log"
    exit 1
fi
